/* src/fp_format_pkg.sv */
package fp_format_pkg;

	////////////////////////////////////////////////////////////////////////////
	// IEEE 754 single precision word layout
	////////////////////////////////////////////////////////////////////////////

	localparam int EXPONENT_WIDTH    = 8;
	localparam int SIGNIFICAND_WIDTH = 23;	// Stored fraction, hidden bit not included
	localparam int TOTAL_WIDTH       = 1 + EXPONENT_WIDTH + SIGNIFICAND_WIDTH;

	// Field view of a word
	typedef struct packed {
		logic                         sign;
		logic [EXPONENT_WIDTH - 1:0]    exponent;
		logic [SIGNIFICAND_WIDTH - 1:0] significand;
	} fp_fields_t;

	// Same 32 bits seen two ways.
	// raw is used for transport and for compare flags,
	// fields is used where the number is taken apart or built up
	typedef union packed {
		logic [TOTAL_WIDTH - 1:0] raw;
		fp_fields_t               fields;
	} fp_word_t;

	////////////////////////////////////////////////////////////////////////////
	// Special encodings produced by the unit
	////////////////////////////////////////////////////////////////////////////

	// Positive quiet NaN, every fraction bit set
	localparam fp_word_t FP_QNAN = {1'b0, {EXPONENT_WIDTH{1'b1}}, {SIGNIFICAND_WIDTH{1'b1}}};

	// Positive infinity
	localparam fp_word_t FP_POS_INF = {1'b0, {EXPONENT_WIDTH{1'b1}}, {SIGNIFICAND_WIDTH{1'b0}}};

endpackage

/* src/alu_op_pkg.sv */
package alu_op_pkg;

	typedef logic [5:0] op_code_t;

	// Arithmetic
	localparam op_code_t OP_FADD = 6'b100000;
	localparam op_code_t OP_FSUB = 6'b100001;

	// Magnitude compares, result is 1 or 0
	localparam op_code_t OP_FGT  = 6'b101100;
	localparam op_code_t OP_FGE  = 6'b101101;
	localparam op_code_t OP_FLT  = 6'b101110;
	localparam op_code_t OP_FLE  = 6'b101111;

	// Operation classes
	typedef logic [1:0] op_class_t;

	localparam op_class_t OP_CLASS_ARITH   = 2'd0;
	localparam op_class_t OP_CLASS_COMPARE = 2'd1;
	localparam op_class_t OP_CLASS_ILLEGAL = 2'd2;

	function automatic op_class_t op_class(input op_code_t op);
		case (op)
			OP_FADD, OP_FSUB:               return OP_CLASS_ARITH;
			OP_FGT, OP_FGE, OP_FLT, OP_FLE: return OP_CLASS_COMPARE;
			default:                        return OP_CLASS_ILLEGAL;
		endcase
	endfunction

endpackage

/* src/fp_adder_stage1.sv */
`timescale 1ns/1ps

module fp_adder_stage1
	import fp_format_pkg::*;
	import alu_op_pkg::*;
(
	input  logic                           clk,
	input  op_code_t                       operation_i,
	input  fp_word_t                       operand1_i,
	input  fp_word_t                       operand2_i,
	output op_code_t                       operation_o,
	output logic [5:0]                     operand_align_shift_o,
	output logic [SIGNIFICAND_WIDTH + 2:0] significand1_o,
	output logic [SIGNIFICAND_WIDTH + 2:0] significand2_o,
	output logic [EXPONENT_WIDTH - 1:0]    exponent1_o,
	output logic [EXPONENT_WIDTH - 1:0]    exponent2_o,
	output logic                           exponent2_larger_o,
	output logic                           result_is_inf_o,
	output logic                           result_is_nan_o
);

	logic                        sign2_effective;
	logic                        hidden1;
	logic                        hidden2;
	logic                        exp2_larger;
	logic [EXPONENT_WIDTH - 1:0] exponent_diff;
	logic [5:0]                  align_shift;
	logic                        op1_max_exp;
	logic                        op2_max_exp;
	logic                        op1_nan;
	logic                        op2_nan;
	logic                        any_nan;
	logic                        any_inf;

	// Subtract and compare both work on operand1 - operand2
	assign sign2_effective = operand2_i.fields.sign
		^ (operation_i == OP_FSUB || op_class(operation_i) == OP_CLASS_COMPARE);

	// Zero exponent means zero or denormal, no hidden one
	assign hidden1 = operand1_i.fields.exponent != '0;
	assign hidden2 = operand2_i.fields.exponent != '0;

	assign exp2_larger = operand2_i.fields.exponent > operand1_i.fields.exponent;

	always_comb
	begin
		if (exp2_larger)
			exponent_diff = operand2_i.fields.exponent - operand1_i.fields.exponent;
		else
			exponent_diff = operand1_i.fields.exponent - operand2_i.fields.exponent;

		// Anything past 63 shifts the smaller operand out completely anyway
		if (exponent_diff > 8'd63)
			align_shift = 6'd63;
		else
			align_shift = exponent_diff[5:0];
	end

	////////////////////////////////////////////////////////////////////////////
	// Special values
	////////////////////////////////////////////////////////////////////////////

	assign op1_max_exp = operand1_i.fields.exponent == {EXPONENT_WIDTH{1'b1}};
	assign op2_max_exp = operand2_i.fields.exponent == {EXPONENT_WIDTH{1'b1}};
	assign op1_nan = op1_max_exp && operand1_i.fields.significand != '0;
	assign op2_nan = op2_max_exp && operand2_i.fields.significand != '0;
	assign any_nan = op1_nan || op2_nan;
	assign any_inf = (op1_max_exp || op2_max_exp) && !any_nan;	// NaN wins

	always_ff @(posedge clk)
	begin
		operation_o           <= operation_i;
		operand_align_shift_o <= align_shift;
		exponent1_o           <= operand1_i.fields.exponent;
		exponent2_o           <= operand2_i.fields.exponent;
		exponent2_larger_o    <= exp2_larger;
		result_is_nan_o       <= any_nan;
		result_is_inf_o       <= any_inf;

		// Top bit holds the sign until stage 2 converts, next bit left free for carry
		significand1_o <= {operand1_i.fields.sign, 1'b0, hidden1, operand1_i.fields.significand};
		significand2_o <= {sign2_effective, 1'b0, hidden2, operand2_i.fields.significand};
	end

endmodule

/* src/fp_adder_stage2.sv */
`timescale 1ns/1ps

module fp_adder_stage2
	import fp_format_pkg::*;
	import alu_op_pkg::*;
(
	input  logic                           clk,
	input  op_code_t                       operation_i,
	input  logic [SIGNIFICAND_WIDTH + 2:0] significand1_i,
	input  logic [SIGNIFICAND_WIDTH + 2:0] significand2_i,
	input  logic [EXPONENT_WIDTH - 1:0]    exponent1_i,
	input  logic [EXPONENT_WIDTH - 1:0]    exponent2_i,
	input  logic                           exponent2_larger_i,
	input  logic [5:0]                     operand_align_shift_i,
	input  logic                           result_is_inf_i,
	input  logic                           result_is_nan_i,
	output op_code_t                       operation_o,
	output logic                           result_is_inf_o,
	output logic                           result_is_nan_o,
	output logic [EXPONENT_WIDTH - 1:0]    exponent_o,
	output logic [SIGNIFICAND_WIDTH + 2:0] significand1_o,
	output logic [SIGNIFICAND_WIDTH + 2:0] significand2_o
);

	logic                           sign1;
	logic                           sign2;
	logic [SIGNIFICAND_WIDTH + 2:0] magnitude1;
	logic [SIGNIFICAND_WIDTH + 2:0] magnitude2;
	logic [SIGNIFICAND_WIDTH + 2:0] aligned1;
	logic [SIGNIFICAND_WIDTH + 2:0] aligned2;
	logic [SIGNIFICAND_WIDTH + 2:0] twos1;
	logic [SIGNIFICAND_WIDTH + 2:0] twos2;

	// Split off the sign carried in from stage 1
	assign sign1      = significand1_i[SIGNIFICAND_WIDTH + 2];
	assign sign2      = significand2_i[SIGNIFICAND_WIDTH + 2];
	assign magnitude1 = {2'b00, significand1_i[SIGNIFICAND_WIDTH:0]};
	assign magnitude2 = {2'b00, significand2_i[SIGNIFICAND_WIDTH:0]};

	////////////////////////////////////////////////////////////////////////////
	// Alignment
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Only the operand with the smaller exponent moves
		if (exponent2_larger_i)
		begin
			aligned1 = magnitude1 >> operand_align_shift_i;
			aligned2 = magnitude2;
		end
		else
		begin
			aligned1 = magnitude1;
			aligned2 = magnitude2 >> operand_align_shift_i;
		end
	end

	// Negative operands into two's complement
	assign twos1 = sign1 ? ~aligned1 + 1'b1 : aligned1;
	assign twos2 = sign2 ? ~aligned2 + 1'b1 : aligned2;

	always_ff @(posedge clk)
	begin
		operation_o     <= operation_i;
		result_is_inf_o <= result_is_inf_i;
		result_is_nan_o <= result_is_nan_i;
		exponent_o      <= exponent2_larger_i ? exponent2_i : exponent1_i;	// Larger one
		significand1_o  <= twos1;
		significand2_o  <= twos2;
	end

endmodule

/* src/multi_cycle_scalar_alu.sv */
`timescale 1ns/1ps

module multi_cycle_scalar_alu
	import fp_format_pkg::*;
	import alu_op_pkg::*;
(
	input  logic     clk,
	input  op_code_t operation_i,
	input  fp_word_t operand1_i,
	input  fp_word_t operand2_i,
	output fp_word_t result_o
);

	// Stage 1 to stage 2
	op_code_t                       add1_operation;
	logic [5:0]                     add1_operand_align_shift;
	logic [SIGNIFICAND_WIDTH + 2:0] add1_significand1;
	logic [SIGNIFICAND_WIDTH + 2:0] add1_significand2;
	logic [EXPONENT_WIDTH - 1:0]    add1_exponent1;
	logic [EXPONENT_WIDTH - 1:0]    add1_exponent2;
	logic                           add1_exponent2_larger;
	logic                           add1_result_is_inf;
	logic                           add1_result_is_nan;

	// Stage 2 to stage 3
	op_code_t                       add2_operation;
	logic [EXPONENT_WIDTH - 1:0]    add2_exponent;
	logic [SIGNIFICAND_WIDTH + 2:0] add2_significand1;
	logic [SIGNIFICAND_WIDTH + 2:0] add2_significand2;
	logic                           add2_result_is_inf;
	logic                           add2_result_is_nan;

	// Stage 3
	logic [SIGNIFICAND_WIDTH + 2:0] sum;
	logic                           result_sign;
	logic [SIGNIFICAND_WIDTH + 1:0] magnitude;	// Sum fits below the sign bit
	logic [4:0]                     top_bit;
	logic [SIGNIFICAND_WIDTH + 1:0] normalized;
	logic signed [EXPONENT_WIDTH + 1:0] exponent_adjusted;
	logic                           result_equal;
	logic                           result_negative;

	fp_adder_stage1 i_stage1 (
		.clk                   (clk),
		.operation_i           (operation_i),
		.operand1_i            (operand1_i),
		.operand2_i            (operand2_i),
		.operation_o           (add1_operation),
		.operand_align_shift_o (add1_operand_align_shift),
		.significand1_o        (add1_significand1),
		.significand2_o        (add1_significand2),
		.exponent1_o           (add1_exponent1),
		.exponent2_o           (add1_exponent2),
		.exponent2_larger_o    (add1_exponent2_larger),
		.result_is_inf_o       (add1_result_is_inf),
		.result_is_nan_o       (add1_result_is_nan)
	);

	fp_adder_stage2 i_stage2 (
		.clk                   (clk),
		.operation_i           (add1_operation),
		.significand1_i        (add1_significand1),
		.significand2_i        (add1_significand2),
		.exponent1_i           (add1_exponent1),
		.exponent2_i           (add1_exponent2),
		.exponent2_larger_i    (add1_exponent2_larger),
		.operand_align_shift_i (add1_operand_align_shift),
		.result_is_inf_i       (add1_result_is_inf),
		.result_is_nan_i       (add1_result_is_nan),
		.operation_o           (add2_operation),
		.result_is_inf_o       (add2_result_is_inf),
		.result_is_nan_o       (add2_result_is_nan),
		.exponent_o            (add2_exponent),
		.significand1_o        (add2_significand1),
		.significand2_o        (add2_significand2)
	);

	////////////////////////////////////////////////////////////////////////////
	// Stage 3, add and renormalize
	////////////////////////////////////////////////////////////////////////////

	assign sum         = add2_significand1 + add2_significand2;
	assign result_sign = sum[SIGNIFICAND_WIDTH + 2];
	assign magnitude   = result_sign ? (~sum[SIGNIFICAND_WIDTH + 1:0] + 1'b1)
		: sum[SIGNIFICAND_WIDTH + 1:0];

	// Priority encoder, highest set bit wins
	always_comb
	begin
		top_bit = '0;
		for (int i = 0; i <= SIGNIFICAND_WIDTH + 1; i++)
			if (magnitude[i])
				top_bit = i[4:0];
	end

	always_comb
	begin
		// Hidden bit belongs at SIGNIFICAND_WIDTH
		if (top_bit == 5'd24)
			normalized = magnitude >> 1;	// Carry out of the add
		else
			normalized = magnitude << (5'd23 - top_bit);
	end

	assign exponent_adjusted = $signed({2'b00, add2_exponent}) + $signed({5'b00000, top_bit})
		- 10'sd23;

	assign result_equal    = magnitude == '0;
	assign result_negative = result_sign;

	// Pack the result or produce a compare flag
	always_comb
	begin
		result_o.raw = '0;
		if (op_class(add2_operation) == OP_CLASS_ARITH)
		begin
			if (add2_result_is_nan)
				result_o = FP_QNAN;
			else if (add2_result_is_inf || exponent_adjusted >= 255)
				result_o = FP_POS_INF;
			else if (!result_equal && exponent_adjusted > 0)	// Denormals flush to zero
			begin
				result_o.fields.sign        = result_sign;
				result_o.fields.exponent    = exponent_adjusted[EXPONENT_WIDTH - 1:0];
				result_o.fields.significand = normalized[SIGNIFICAND_WIDTH - 1:0];
			end
		end
		else
		begin
			case (add2_operation)
				OP_FGT:  result_o.raw[0] = !result_equal && !result_negative;
				OP_FGE:  result_o.raw[0] = !result_negative;
				OP_FLT:  result_o.raw[0] = result_negative;
				OP_FLE:  result_o.raw[0] = result_equal || result_negative;
				default: result_o.raw[0] = 1'b0;
			endcase
		end
	end

endmodule

/* src/fp_issue_control.sv */
`timescale 1ns/1ps

module fp_issue_control
	import fp_format_pkg::*;
	import alu_op_pkg::*;
(
	input  logic     clk,
	input  logic     rst_i,
	input  logic     op_valid_i,
	input  op_code_t operation_i,
	input  fp_word_t alu_result_i,
	output fp_word_t result_o,
	output logic     result_valid_o,
	output logic     illegal_op_o
);

	logic issue_illegal;
	logic valid_s1;
	logic valid_s2;
	logic illegal_s1;
	logic illegal_s2;

	// Opcode check happens once, at issue
	assign issue_illegal = op_class(operation_i) == OP_CLASS_ILLEGAL;

	////////////////////////////////////////////////////////////////////////////
	// Valid tracking, lines up with the two datapath register stages
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			valid_s1   <= 1'b0;
			valid_s2   <= 1'b0;
			illegal_s1 <= 1'b0;
			illegal_s2 <= 1'b0;
		end
		else
		begin
			valid_s1   <= op_valid_i;
			illegal_s1 <= op_valid_i && issue_illegal;
			valid_s2   <= valid_s1;
			illegal_s2 <= illegal_s1;
		end
	end

	// Result register and done pulse
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			result_o       <= '0;
			result_valid_o <= 1'b0;
			illegal_op_o   <= 1'b0;
		end
		else
		begin
			result_valid_o <= valid_s2;	// One cycle only
			if (valid_s2)
			begin
				result_o     <= illegal_s2 ? fp_word_t'('0) : alu_result_i;
				illegal_op_o <= illegal_s2;
			end
		end
	end

endmodule

/* src/fp_scalar_unit.sv */
`timescale 1ns/1ps

module fp_scalar_unit
	import fp_format_pkg::*;
	import alu_op_pkg::*;
(
	input  logic     clk,
	input  logic     rst_i,
	input  logic     op_valid_i,
	input  op_code_t operation_i,
	input  fp_word_t operand1_i,
	input  fp_word_t operand2_i,
	output fp_word_t result_o,
	output logic     result_valid_o,
	output logic     illegal_op_o
);

	fp_word_t alu_result;	// Stage 3 output, combinational

	// Datapath runs every cycle, control decides what counts
	multi_cycle_scalar_alu i_multi_cycle_scalar_alu (
		.clk         (clk),
		.operation_i (operation_i),
		.operand1_i  (operand1_i),
		.operand2_i  (operand2_i),
		.result_o    (alu_result)
	);

	fp_issue_control i_fp_issue_control (
		.clk            (clk),
		.rst_i          (rst_i),
		.op_valid_i     (op_valid_i),
		.operation_i    (operation_i),
		.alu_result_i   (alu_result),
		.result_o       (result_o),
		.result_valid_o (result_valid_o),
		.illegal_op_o   (illegal_op_o)
	);

endmodule

/* testbench/tb_fp_scalar_unit.sv */
`timescale 1ns/1ps

module tb_fp_scalar_unit
	import fp_format_pkg::*;
	import alu_op_pkg::*;
();

	localparam int NAME_CHARS    = 24;
	localparam int MAX_TESTS     = 64;
	localparam int PULSE_EDGES   = 3;	// Strobe edge to result edge
	localparam int PULSE_TIMEOUT = 20;	// Cycles

	logic     clk;
	logic     rst_i;
	logic     op_valid_i;
	op_code_t operation_i;
	fp_word_t operand1_i;
	fp_word_t operand2_i;
	fp_word_t result_o;
	logic     result_valid_o;
	logic     illegal_op_o;

	// Test table filled from the vector file
	logic [8 * NAME_CHARS - 1:0] test_name [MAX_TESTS];
	op_code_t                    test_op [MAX_TESTS];
	fp_word_t                    test_a [MAX_TESTS];
	fp_word_t                    test_b [MAX_TESTS];
	fp_word_t                    test_expected [MAX_TESTS];
	logic                        test_illegal [MAX_TESTS];
	int                          num_tests;

	int pending_index[$];	// Issued tests with the oldest first
	int pending_edge[$];
	int edge_count = 0;
	int value_errors;
	int protocol_errors;

	fp_scalar_unit i_fp_scalar_unit (
		.clk            (clk),
		.rst_i          (rst_i),
		.op_valid_i     (op_valid_i),
		.operation_i    (operation_i),
		.operand1_i     (operand1_i),
		.operand2_i     (operand2_i),
		.result_o       (result_o),
		.result_valid_o (result_valid_o),
		.illegal_op_o   (illegal_op_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		edge_count <= edge_count + 1;

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_result(input logic [8 * NAME_CHARS - 1:0] name,
		input fp_word_t expected, input fp_word_t actual);
		if (actual.raw !== expected.raw)
		begin
			$display("FAIL %0s result: expected %08h, actual %08h", name, expected.raw,
				actual.raw);
			value_errors++;
		end
	endtask

	task automatic check_flag(input logic [8 * NAME_CHARS - 1:0] name, input string flag,
		input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("FAIL %0s %0s: expected %b, actual %b", name, flag, expected, actual);
			value_errors++;
		end
	endtask

	task automatic load_tests();
		int                          fd;
		int                          n;
		logic [8 * 128 - 1:0]        line;
		logic [8 * NAME_CHARS - 1:0] name;
		op_code_t                    op;
		logic [TOTAL_WIDTH - 1:0]    a;
		logic [TOTAL_WIDTH - 1:0]    b;
		logic [TOTAL_WIDTH - 1:0]    expected;
		logic                        illegal;
		num_tests = 0;
		fd = $fopen("testbench/fp_scalar_tests.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the test vector file");
			protocol_errors++;
			return;
		end
		while ($fgets(line, fd) != 0 && num_tests < MAX_TESTS)
		begin
			// Comment and blank lines never scan all six fields
			n = $sscanf(line, "%s %h %h %h %h %h", name, op, a, b, expected, illegal);
			if (n == 6)
			begin
				test_name[num_tests]         = name;
				test_op[num_tests]           = op;
				test_a[num_tests].raw        = a;
				test_b[num_tests].raw        = b;
				test_expected[num_tests].raw = expected;
				test_illegal[num_tests]      = illegal;
				num_tests++;
			end
		end
		$fclose(fd);
	endtask

	// One strobe on every cycle without gaps
	task automatic issue_tests();
		for (int i = 0; i < num_tests; i++)
		begin
			@(posedge clk);
			op_valid_i  <= 1'b1;
			operation_i <= test_op[i];
			operand1_i  <= test_a[i];
			operand2_i  <= test_b[i];
			pending_index.push_back(i);
			pending_edge.push_back(edge_count + 1);	// Counter still holds the last edge
		end
		@(posedge clk);
		op_valid_i <= 1'b0;
	endtask

	task automatic wait_for_pulse(output logic seen);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!result_valid_o && waited < PULSE_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		seen = result_valid_o;
	endtask

	task automatic collect_results();
		logic seen;
		int   idx;
		for (int i = 0; i < num_tests; i++)
		begin
			wait_for_pulse(seen);
			if (!seen)
			begin
				$display("Timed out waiting for the result pulse of operation %0d", i);
				protocol_errors++;
				return;
			end
			idx = pending_index.pop_front();
			if (edge_count - pending_edge.pop_front() != PULSE_EDGES)
			begin
				$display("The result pulse of %0s came at the wrong edge", test_name[idx]);
				protocol_errors++;
			end
			check_result(test_name[idx], test_expected[idx], result_o);
			check_flag(test_name[idx], "illegal", test_illegal[idx], illegal_op_o);
		end

		// Every issued operation has been answered by now
		for (int i = 0; i < PULSE_EDGES + 2; i++)
		begin
			@(negedge clk);
			if (result_valid_o)
			begin
				$display("A result pulse arrived with no operation in flight");
				protocol_errors++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		rst_i           = 1'b1;
		op_valid_i      = 1'b0;
		operation_i     = OP_FADD;
		operand1_i      = '0;
		operand2_i      = '0;
		value_errors    = 0;
		protocol_errors = 0;
		load_tests();

		repeat (4) @(posedge clk);
		rst_i <= 1'b0;
		@(negedge clk);
		check_result("reset", '0, result_o);
		check_flag("reset", "valid", 1'b0, result_valid_o);
		check_flag("reset", "illegal", 1'b0, illegal_op_o);

		if (num_tests == 0)
		begin
			$display("No test vectors were loaded");
			protocol_errors++;
		end
		else
		begin
			fork
				issue_tests();
				collect_results();
			join
		end

		$display("Errors: %0d wrong values, %0d protocol", value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* testbench/fp_scalar_tests.txt */
# name  opcode  operand1  operand2  expected  illegal
# opcode, operands and expected result in hex; illegal is 0 or 1
add_1p5_2p25        20 3fc00000 40100000 40700000 0
add_8_neg0p5        20 41000000 bf000000 40f00000 0
add_1_1_carry       20 3f800000 3f800000 40000000 0
add_neg3_1          20 c0400000 3f800000 c0000000 0
add_zero_5          20 00000000 40a00000 40a00000 0
add_100_0p25        20 42c80000 3e800000 42c88000 0
add_neg1p25_neg2p5  20 bfa00000 c0200000 c0700000 0
add_1024_1          20 44800000 3f800000 44802000 0
add_1_neg0p75       20 3f800000 bf400000 3e800000 0
sub_5_3             21 40a00000 40400000 40000000 0
sub_3_5             21 40400000 40a00000 c0000000 0
sub_7p5_7p5         21 40f00000 40f00000 00000000 0
sub_neg2_1p5        21 c0000000 3fc00000 c0600000 0
sub_0p5_neg0p25     21 3f000000 be800000 3f400000 0
sub_10_zero         21 41200000 00000000 41200000 0
fgt_2_1             2c 40000000 3f800000 00000001 0
fgt_1_1             2c 3f800000 3f800000 00000000 0
fgt_1_2             2c 3f800000 40000000 00000000 0
fgt_neg1_neg2       2c bf800000 c0000000 00000001 0
fge_1_1             2d 3f800000 3f800000 00000001 0
fge_neg3_neg2       2d c0400000 c0000000 00000000 0
fge_2_neg2          2d 40000000 c0000000 00000001 0
fge_zero_negzero    2d 00000000 80000000 00000001 0
flt_neg3_neg2       2e c0400000 c0000000 00000001 0
flt_2p5_2p5         2e 40200000 40200000 00000000 0
flt_4_1             2e 40800000 3f800000 00000000 0
fle_2p5_2p5         2f 40200000 40200000 00000001 0
fle_1_neg1          2f 3f800000 bf800000 00000000 0
fle_neg1_1          2f bf800000 3f800000 00000001 0
nan_add             20 7fc00000 3f800000 7fffffff 0
nan_sub             21 3f800000 ffc00001 7fffffff 0
inf_add             20 7f800000 3f800000 7f800000 0
neginf_sub          21 ff800000 40000000 7f800000 0
inf_plus_nan        20 7f800000 7fc00000 7fffffff 0
illegal_3f          3f 3f800000 3f800000 00000000 1
illegal_00          00 40000000 40000000 00000000 1
add_after_illegal   20 3fc00000 40100000 40700000 0
illegal_24          24 3f800000 3f800000 00000000 1
sub_after_illegal   21 40a00000 40400000 40000000 0

/* verilog.f */
src/fp_format_pkg.sv
src/alu_op_pkg.sv
src/fp_adder_stage1.sv
src/fp_adder_stage2.sv
src/multi_cycle_scalar_alu.sv
src/fp_issue_control.sv
src/fp_scalar_unit.sv
testbench/tb_fp_scalar_unit.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fp_scalar_unit
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
